/* dual_dispatch.f */
+incdir+.
rob_pkg.sv
inst_pkg.sv
dispatch.sv
issue_queue.sv
rob_alloc.sv
dual_dispatch.sv
tb_dual_dispatch.sv

/* Bender.yml */
package:
  name: dual_dispatch

export_include_dirs:
  - .

sources:
  - rob_pkg.sv
  - inst_pkg.sv
  - dispatch.sv
  - issue_queue.sv
  - rob_alloc.sv
  - dual_dispatch.sv
  - target: test
    files:
      - tb_dual_dispatch.sv

/* tb_dual_dispatch.sv */
//----------------------------------------
// Directed testbench for the dispatch backend
// Model queues per issue port and for the ROB
//----------------------------------------
`include "uarch_params.svh"

module tb_dual_dispatch
    import inst_pkg::*;
    import rob_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    // Routing 21, same queue 5, ROB full 18, retire 6, back-pressure 16
    localparam int TOTAL_INST  = 66;
    localparam int WATCHDOG_NS = TOTAL_INST * 20 * CLK_PERIOD + 2000;

    logic          clk;
    logic          rst_n;
    renamed_inst_t inst0, inst1;
    logic          dispatch_rdy;
    logic          alu_iss_valid, mdu_iss_valid, lsq_iss_valid;
    renamed_inst_t alu_iss_inst, mdu_iss_inst, lsq_iss_inst;
    logic          alu_iss_ready, mdu_iss_ready, lsq_iss_ready;
    logic          complete_valid;
    rob_tag_t      complete_tag;
    logic          retire_valid;
    retire_rec_t   retire_rec;
    logic          retire_ready;

    // Expected contents, program order
    renamed_inst_t alu_m[$], mdu_m[$], lsq_m[$];
    retire_rec_t   rob_m[$];
    rob_tag_t      tag_ctr;

    integer        seed;
    logic [31:0]   rnd;
    logic          lsq_rand;
    logic          lsq_rdy_next;
    int            inst_errors, retire_errors, ctrl_errors, other_errors;

    dual_dispatch dual_dispatch_inst (
        .clk(clk), .rst_n(rst_n), .inst0(inst0), .inst1(inst1), .dispatch_rdy(dispatch_rdy),
        .alu_iss_valid(alu_iss_valid), .alu_iss_inst(alu_iss_inst),
        .alu_iss_ready(alu_iss_ready),
        .mdu_iss_valid(mdu_iss_valid), .mdu_iss_inst(mdu_iss_inst),
        .mdu_iss_ready(mdu_iss_ready),
        .lsq_iss_valid(lsq_iss_valid), .lsq_iss_inst(lsq_iss_inst),
        .lsq_iss_ready(lsq_iss_ready),
        .complete_valid(complete_valid), .complete_tag(complete_tag),
        .retire_valid(retire_valid), .retire_rec(retire_rec), .retire_ready(retire_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //----------------------------------------
    // Compare tasks
    //----------------------------------------
    task automatic check_inst(input fu_class_t cls, input renamed_inst_t got,
                              input renamed_inst_t exp);
        string sig;
        sig = cls.name();
        sig = {sig.tolower(), "_iss_inst"};
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", sig, got, exp);
            inst_errors++;
        end
    endtask

    task automatic check_retire(input retire_rec_t got, input retire_rec_t exp);
        if (got !== exp) begin
            $display("[ERROR] retire_rec: got 0x%h, expected 0x%h", got, exp);
            retire_errors++;
        end
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", sig, got, exp);
            ctrl_errors++;
        end
    endtask

    //----------------------------------------
    // Stimulus and reference model
    //----------------------------------------
    // Loads and stores go to the LSQ even with muldiv set
    function automatic fu_class_t expected_class(input renamed_inst_t i);
        if (i.is_load || i.is_store) begin
            return LSQ;
        end
        return i.is_muldiv ? MDU : ALU;
    endfunction

    // Random fields, flags picked for the wanted queue
    function automatic renamed_inst_t rand_inst(input fu_class_t k);
        renamed_inst_t i;
        logic [31:0]   r;
        i          = '0;
        r          = $random(seed);
        i.is_valid = 1'b1;
        i.pc       = $random(seed);
        i.rd       = r[4:0];
        i.prd      = r[10:5];
        i.prs1     = r[16:11];
        i.prs2     = r[22:17];
        i.has_rd   = r[23];
        // Junk tag, dispatch must overwrite it
        i.rob_tag  = r[27:24];
        case (k)
            MDU: i.is_muldiv = 1'b1;
            LSQ: begin
                i.is_load   = r[28];
                i.is_store  = !r[28];
                i.is_muldiv = r[29];
            end
            default: begin
                i.is_branch = r[30];
                i.is_jump   = r[31] && !r[30];
            end
        endcase
        return i;
    endfunction

    // Accepted instruction gets the next tag
    task automatic record_inst(input renamed_inst_t i);
        renamed_inst_t e;
        retire_rec_t   r;
        if (i.is_valid) begin
            e          = i;
            e.rob_tag  = tag_ctr;
            r.rob_tag  = tag_ctr;
            r.pc       = i.pc;
            r.rd       = i.rd;
            r.has_rd   = i.has_rd;
            r.is_store = i.is_store;
            case (expected_class(i))
                MDU:     mdu_m.push_back(e);
                LSQ:     lsq_m.push_back(e);
                default: alu_m.push_back(e);
            endcase
            rob_m.push_back(r);
            tag_ctr++;
        end
    endtask

    task automatic drive_pair(input renamed_inst_t a, input renamed_inst_t b);
        @(posedge clk);
        #1;
        inst0 = a;
        inst1 = b;
    endtask

    // Transfer happens on the edge after dispatch_rdy is seen high
    task automatic accept_pair(input renamed_inst_t a, input renamed_inst_t b);
        int n;
        n = 0;
        @(negedge clk);
        while (!dispatch_rdy && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (dispatch_rdy) begin
            record_inst(a);
            record_inst(b);
        end else begin
            $display("dispatch never accepted the pair at pc %h", a.pc);
            other_errors++;
        end
        @(posedge clk);
        #1;
        inst0 = '0;
        inst1 = '0;
    endtask

    task automatic send_pair(input renamed_inst_t a, input renamed_inst_t b);
        drive_pair(a, b);
        accept_pair(a, b);
    endtask

    function automatic int pending(input logic with_rob);
        return alu_m.size() + mdu_m.size() + lsq_m.size() + (with_rob ? rob_m.size() : 0);
    endfunction

    task automatic wait_until_empty(input logic with_rob, input string what);
        int n;
        n = 0;
        while (pending(with_rob) != 0 && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (pending(with_rob) != 0) begin
            $display("%s did not drain within %0d cycles", what, n);
            other_errors++;
        end
    endtask

    // Completes the oldest n entries in program order
    task automatic complete_first(input int n);
        rob_tag_t tags[$];
        for (int i = 0; i < n; i++) begin
            tags.push_back(rob_m[i].rob_tag);
        end
        foreach (tags[i]) begin
            @(posedge clk);
            #1;
            complete_valid = 1'b1;
            complete_tag   = tags[i];
        end
        @(posedge clk);
        #1;
        complete_valid = 1'b0;
    endtask

    task automatic complete_all();
        complete_first(rob_m.size());
        wait_until_empty(1'b1, "ROB");
    endtask

    //----------------------------------------
    // Monitors, sampled mid-cycle
    //----------------------------------------
    task automatic take_issue(input fu_class_t cls, input renamed_inst_t got);
        renamed_inst_t exp;
        logic          found;
        found = 1'b1;
        if (cls == ALU && alu_m.size() != 0) begin
            exp = alu_m.pop_front();
        end else if (cls == MDU && mdu_m.size() != 0) begin
            exp = mdu_m.pop_front();
        end else if (cls == LSQ && lsq_m.size() != 0) begin
            exp = lsq_m.pop_front();
        end else begin
            found = 1'b0;
            $display("%s queue issued an instruction that was never dispatched", cls.name());
            other_errors++;
        end
        if (found) begin
            check_inst(cls, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (alu_iss_valid && alu_iss_ready) take_issue(ALU, alu_iss_inst);
            if (mdu_iss_valid && mdu_iss_ready) take_issue(MDU, mdu_iss_inst);
            if (lsq_iss_valid && lsq_iss_ready) take_issue(LSQ, lsq_iss_inst);
            if (retire_valid && retire_ready) begin
                if (rob_m.size() == 0) begin
                    $display("ROB retired an entry that was never allocated");
                    other_errors++;
                end else begin
                    check_retire(retire_rec, rob_m.pop_front());
                end
            end
        end
    end

    // Random LSQ ready, drawn mid-cycle and applied after the edge
    always @(negedge clk) begin
        if (lsq_rand) begin
            rnd          = $random(seed);
            lsq_rdy_next = rnd[0];
        end
    end

    always @(posedge clk) begin
        #1;
        if (lsq_rand) begin
            lsq_iss_ready = lsq_rdy_next;
        end
    end

    //----------------------------------------
    // Directed tests
    //----------------------------------------
    task automatic reset_state();
        @(negedge clk);
        check_bit("alu_iss_valid", alu_iss_valid, 1'b0);
        check_bit("mdu_iss_valid", mdu_iss_valid, 1'b0);
        check_bit("lsq_iss_valid", lsq_iss_valid, 1'b0);
        check_bit("retire_valid", retire_valid, 1'b0);
        check_bit("dispatch_rdy", dispatch_rdy, 1'b1);
    endtask

    // All nine class pairs, then lone slot-0 instructions
    task automatic routing();
        for (int a = 1; a <= 3; a++) begin
            for (int b = 1; b <= 3; b++) begin
                send_pair(rand_inst(fu_class_t'(a)), rand_inst(fu_class_t'(b)));
            end
            wait_until_empty(1'b0, "issue queues");
            complete_all();
        end
        for (int a = 1; a <= 3; a++) begin
            send_pair(rand_inst(fu_class_t'(a)), '0);
        end
        wait_until_empty(1'b0, "issue queues");
        complete_all();
    endtask

    task automatic same_queue_pair();
        renamed_inst_t a, b;
        @(posedge clk);
        #1;
        mdu_iss_ready = 1'b0;
        // Three of four MDU entries in use
        send_pair(rand_inst(MDU), rand_inst(MDU));
        send_pair(rand_inst(MDU), '0);
        a = rand_inst(MDU);
        b = rand_inst(MDU);
        drive_pair(a, b);
        repeat (4) begin
            @(negedge clk);
            check_bit("dispatch_rdy", dispatch_rdy, 1'b0);
            check_bit("mdu_iss_valid", mdu_iss_valid, 1'b1);
            check_inst(MDU, mdu_iss_inst, mdu_m[0]);
        end
        // One issue leaves room for both
        @(posedge clk);
        #1;
        mdu_iss_ready = 1'b1;
        @(posedge clk);
        #1;
        mdu_iss_ready = 1'b0;
        accept_pair(a, b);
        @(posedge clk);
        #1;
        mdu_iss_ready = 1'b1;
        wait_until_empty(1'b0, "MDU queue");
        complete_all();
    endtask

    task automatic rob_full();
        renamed_inst_t a, b;
        for (int i = 0; i < `ROB_DEPTH; i += 2) begin
            send_pair(rand_inst(fu_class_t'(1 + i % 3)), rand_inst(fu_class_t'(1 + (i + 1) % 3)));
        end
        a = rand_inst(ALU);
        b = rand_inst(LSQ);
        drive_pair(a, b);
        repeat (4) begin
            @(negedge clk);
            check_bit("dispatch_rdy", dispatch_rdy, 1'b0);
        end
        // Two retires make room for the waiting pair
        complete_first(2);
        accept_pair(a, b);
        wait_until_empty(1'b0, "issue queues");
        complete_all();
    endtask

    task automatic in_order_retire();
        rob_tag_t tags[$];
        for (int i = 0; i < 3; i++) begin
            send_pair(rand_inst(fu_class_t'(i + 1)), rand_inst(fu_class_t'(3 - i)));
        end
        wait_until_empty(1'b0, "issue queues");
        @(posedge clk);
        #1;
        retire_ready = 1'b0;
        foreach (rob_m[i]) begin
            tags.push_back(rob_m[i].rob_tag);
        end
        // Youngest first, head stays not done until the end
        for (int i = tags.size() - 1; i >= 0; i--) begin
            @(posedge clk);
            #1;
            complete_valid = 1'b1;
            complete_tag   = tags[i];
            @(negedge clk);
            check_bit("retire_valid", retire_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        complete_valid = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bit("retire_valid", retire_valid, 1'b1);
            check_retire(retire_rec, rob_m[0]);
        end
        @(posedge clk);
        #1;
        retire_ready = 1'b1;
        wait_until_empty(1'b1, "ROB");
    endtask

    task automatic issue_backpressure();
        renamed_inst_t pool[16];
        foreach (pool[i]) begin
            pool[i] = rand_inst(LSQ);
        end
        lsq_rand = 1'b1;
        for (int i = 0; i < 16; i += 2) begin
            send_pair(pool[i], pool[i + 1]);
        end
        wait_until_empty(1'b0, "LSQ");
        lsq_rand = 1'b0;
        @(posedge clk);
        #1;
        lsq_iss_ready = 1'b1;
        complete_all();
    endtask

    //----------------------------------------
    // Main sequence and watchdog
    //----------------------------------------
    initial begin
        seed           = 47663;
        clk            = 1'b0;
        rst_n          = 1'b0;
        inst0          = '0;
        inst1          = '0;
        alu_iss_ready  = 1'b1;
        mdu_iss_ready  = 1'b1;
        lsq_iss_ready  = 1'b1;
        complete_valid = 1'b0;
        complete_tag   = '0;
        retire_ready   = 1'b1;
        lsq_rand       = 1'b0;
        lsq_rdy_next   = 1'b1;
        tag_ctr        = '0;
        inst_errors    = 0;
        retire_errors  = 0;
        ctrl_errors    = 0;
        other_errors   = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        routing();
        same_queue_pair();
        rob_full();
        in_order_retire();
        issue_backpressure();
        repeat (4) @(posedge clk);
        $display("errors: inst %0d, retire %0d, control %0d, other %0d",
                 inst_errors, retire_errors, ctrl_errors, other_errors);
        if (inst_errors + retire_errors + ctrl_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run is hung", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* dual_dispatch.sv */
//----------------------------------------
// Top of the two-wide dispatch backend
// Dispatch feeding three issue queues and the ROB
//----------------------------------------
`include "uarch_params.svh"

module dual_dispatch
    import inst_pkg::*;
    import rob_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    // Rename side
    input  renamed_inst_t inst0,
    input  renamed_inst_t inst1,
    output logic          dispatch_rdy,
    // Issue ports
    output logic          alu_iss_valid,
    output renamed_inst_t alu_iss_inst,
    input  logic          alu_iss_ready,
    output logic          mdu_iss_valid,
    output renamed_inst_t mdu_iss_inst,
    input  logic          mdu_iss_ready,
    output logic          lsq_iss_valid,
    output renamed_inst_t lsq_iss_inst,
    input  logic          lsq_iss_ready,
    // Completion and retire
    input  logic          complete_valid,
    input  rob_tag_t      complete_tag,
    output logic          retire_valid,
    output retire_rec_t   retire_rec,
    input  logic          retire_ready
);

    logic [1:0]    alu_we, mdu_we, lsq_we, rob_we;
    renamed_inst_t alu_entry0, alu_entry1;
    renamed_inst_t mdu_entry0, mdu_entry1;
    renamed_inst_t lsq_entry0, lsq_entry1;
    slot_rdy_t     alu_rdy, mdu_rdy, lsq_rdy, rob_rdy;
    rob_entry_t    rob_entry0, rob_entry1;
    rob_tag_t      alloc_tag0, alloc_tag1;

    dispatch u_dispatch (
        .inst0(inst0), .inst1(inst1), .dispatch_rdy(dispatch_rdy),
        .alu_rdy(alu_rdy), .mdu_rdy(mdu_rdy), .lsq_rdy(lsq_rdy), .rob_rdy(rob_rdy),
        .alloc_tag0(alloc_tag0), .alloc_tag1(alloc_tag1),
        .alu_we(alu_we), .alu_entry0(alu_entry0), .alu_entry1(alu_entry1),
        .mdu_we(mdu_we), .mdu_entry0(mdu_entry0), .mdu_entry1(mdu_entry1),
        .lsq_we(lsq_we), .lsq_entry0(lsq_entry0), .lsq_entry1(lsq_entry1),
        .rob_we(rob_we), .rob_entry0(rob_entry0), .rob_entry1(rob_entry1)
    );

    //----------------------------------------
    // Issue queues
    //----------------------------------------
    issue_queue #(.DEPTH(`ALU_RS_DEPTH)) alu_rs (
        .clk(clk), .rst_n(rst_n), .we(alu_we), .entry0(alu_entry0), .entry1(alu_entry1),
        .rdy(alu_rdy), .iss_valid(alu_iss_valid), .iss_inst(alu_iss_inst),
        .iss_ready(alu_iss_ready)
    );

    issue_queue #(.DEPTH(`MDU_RS_DEPTH)) mdu_rs (
        .clk(clk), .rst_n(rst_n), .we(mdu_we), .entry0(mdu_entry0), .entry1(mdu_entry1),
        .rdy(mdu_rdy), .iss_valid(mdu_iss_valid), .iss_inst(mdu_iss_inst),
        .iss_ready(mdu_iss_ready)
    );

    issue_queue #(.DEPTH(`LSQ_DEPTH)) lsq (
        .clk(clk), .rst_n(rst_n), .we(lsq_we), .entry0(lsq_entry0), .entry1(lsq_entry1),
        .rdy(lsq_rdy), .iss_valid(lsq_iss_valid), .iss_inst(lsq_iss_inst),
        .iss_ready(lsq_iss_ready)
    );

    // Reorder buffer
    rob_alloc u_rob (
        .clk(clk), .rst_n(rst_n), .we(rob_we), .entry0(rob_entry0), .entry1(rob_entry1),
        .rdy(rob_rdy), .alloc_tag0(alloc_tag0), .alloc_tag1(alloc_tag1),
        .complete_valid(complete_valid), .complete_tag(complete_tag),
        .retire_valid(retire_valid), .retire_rec(retire_rec), .retire_ready(retire_ready)
    );

endmodule

/* rob_alloc.sv */
//----------------------------------------
// Circular reorder buffer with two allocations per cycle
// Completion by tag and in-order retire from the head
//----------------------------------------
`include "uarch_params.svh"

module rob_alloc
    import rob_pkg::*;
    import inst_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // Allocation from dispatch where bit 1 implies bit 0
    input  logic [1:0]  we,
    input  rob_entry_t  entry0,
    input  rob_entry_t  entry1,
    output slot_rdy_t   rdy,
    output rob_tag_t    alloc_tag0,
    output rob_tag_t    alloc_tag1,
    // Completion
    input  logic        complete_valid,
    input  rob_tag_t    complete_tag,
    // Retire handshake
    output logic        retire_valid,
    output retire_rec_t retire_rec,
    input  logic        retire_ready
);

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    rob_entry_t       rob_q [`ROB_DEPTH];
    rob_tag_t         head, tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic [1:0]       n_alloc;
    logic             do_retire;

    // Tail and the slot after it
    assign alloc_tag0 = tail;
    assign alloc_tag1 = tail + rob_tag_t'(1);

    assign free_cnt    = CNT_W'(`ROB_DEPTH) - count;
    assign rdy.has_one = free_cnt >= CNT_W'(1);
    assign rdy.has_two = free_cnt >= CNT_W'(2);
    assign n_alloc     = {1'b0, we[0]} + {1'b0, we[1]};

    //----------------------------------------
    // Head record and retire
    //----------------------------------------
    assign retire_valid        = rob_q[head].is_valid && rob_q[head].is_done;
    assign retire_rec.rob_tag  = head;
    assign retire_rec.pc       = rob_q[head].pc;
    assign retire_rec.rd       = rob_q[head].rd;
    assign retire_rec.has_rd   = rob_q[head].has_rd;
    assign retire_rec.is_store = rob_q[head].is_store;
    assign do_retire           = retire_valid && retire_ready;

    // Allocate first, mark done next and clear the retired head last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                rob_q[i] <= '0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (we[0]) begin
                rob_q[alloc_tag0] <= entry0;
            end
            if (we[1]) begin
                rob_q[alloc_tag1] <= entry1;
            end
            if (complete_valid) begin
                rob_q[complete_tag].is_done <= 1'b1;
            end
            if (do_retire) begin
                rob_q[head] <= '0;
                head        <= head + rob_tag_t'(1);
            end
            tail  <= tail + rob_tag_t'(n_alloc);
            count <= count + CNT_W'(n_alloc) - CNT_W'(do_retire);
        end
    end

endmodule

/* issue_queue.sv */
//----------------------------------------
// In-order issue queue, two writes and one issue per cycle
// Used for ALU, MDU and LSQ with different depths
//----------------------------------------
module issue_queue
    import inst_pkg::*;
#(
    // Power of two, pointers wrap naturally
    parameter int DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    // Write side from dispatch
    input  logic [1:0]    we,
    input  renamed_inst_t entry0,
    input  renamed_inst_t entry1,
    output slot_rdy_t     rdy,
    // Issue side
    output logic          iss_valid,
    output renamed_inst_t iss_inst,
    input  logic          iss_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    renamed_inst_t    mem [DEPTH];
    logic [PTR_W-1:0] head, tail;
    logic [PTR_W-1:0] wr_ptr1;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic [1:0]       n_wr;
    logic             do_issue;

    //----------------------------------------
    // Free space and issue handshake
    //----------------------------------------
    // Ignores a same-cycle issue on purpose
    assign free_cnt    = CNT_W'(DEPTH) - count;
    assign rdy.has_one = free_cnt >= CNT_W'(1);
    assign rdy.has_two = free_cnt >= CNT_W'(2);

    assign iss_valid = count != '0;
    assign iss_inst  = mem[head];
    assign do_issue  = iss_valid && iss_ready;

    // Second write lands after the first when both are set
    assign n_wr    = {1'b0, we[0]} + {1'b0, we[1]};
    assign wr_ptr1 = we[0] ? tail + PTR_W'(1) : tail;

    // Entry storage
    always_ff @(posedge clk) begin
        if (we[0]) begin
            mem[tail] <= entry0;
        end
        if (we[1]) begin
            mem[wr_ptr1] <= entry1;
        end
    end

    //----------------------------------------
    // Pointers and occupancy
    //----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + PTR_W'(n_wr);
            count <= count + CNT_W'(n_wr) - CNT_W'(do_issue);
            if (do_issue) begin
                head <= head + PTR_W'(1);
            end
        end
    end

endmodule

/* dispatch.sv */
//----------------------------------------
// Combinational dispatch of a renamed pair
// Routes to ALU/MDU/LSQ queues and builds ROB entries
//----------------------------------------
module dispatch
    import inst_pkg::*;
    import rob_pkg::*;
(
    // Rename side
    input  renamed_inst_t inst0,
    input  renamed_inst_t inst1,
    output logic          dispatch_rdy,
    // Free space from queues and ROB
    input  slot_rdy_t     alu_rdy,
    input  slot_rdy_t     mdu_rdy,
    input  slot_rdy_t     lsq_rdy,
    input  slot_rdy_t     rob_rdy,
    input  rob_tag_t      alloc_tag0,
    input  rob_tag_t      alloc_tag1,
    // Queue write ports
    output logic [1:0]    alu_we,
    output renamed_inst_t alu_entry0,
    output renamed_inst_t alu_entry1,
    output logic [1:0]    mdu_we,
    output renamed_inst_t mdu_entry0,
    output renamed_inst_t mdu_entry1,
    output logic [1:0]    lsq_we,
    output renamed_inst_t lsq_entry0,
    output renamed_inst_t lsq_entry1,
    // ROB write port, bit 0 is always the older write
    output logic [1:0]    rob_we,
    output rob_entry_t    rob_entry0,
    output rob_entry_t    rob_entry1
);

    // Loads and stores win over muldiv
    function automatic fu_class_t classify(input renamed_inst_t inst);
        fu_class_t cls;
        if (!inst.is_valid) begin
            cls = NONE;
        end else if (inst.is_load || inst.is_store) begin
            cls = LSQ;
        end else if (inst.is_muldiv) begin
            cls = MDU;
        end else begin
            cls = ALU;
        end
        return cls;
    endfunction

    // Entries needed in one queue by the pair
    function automatic logic [1:0] need_of(input fu_class_t want, input fu_class_t c0,
                                           input fu_class_t c1);
        return {1'b0, c0 == want} + {1'b0, c1 == want};
    endfunction

    // Need against free-space encoding
    function automatic logic fits(input logic [1:0] need, input slot_rdy_t rdy);
        logic ok;
        case (need)
            2'd0:    ok = 1'b1;
            2'd1:    ok = rdy.has_one;
            default: ok = rdy.has_two;
        endcase
        return ok;
    endfunction

    // New ROB entry, not yet done
    function automatic rob_entry_t gen_rob_entry(input renamed_inst_t inst);
        rob_entry_t e;
        e           = '0;
        e.is_valid  = inst.is_valid;
        e.pc        = inst.pc;
        e.rd        = inst.rd;
        e.has_rd    = inst.has_rd;
        e.is_branch = inst.is_branch;
        e.is_jump   = inst.is_jump;
        e.is_store  = inst.is_store;
        return e;
    endfunction

    fu_class_t     cls0, cls1;
    logic [1:0]    rob_need;
    logic          all_ok;
    renamed_inst_t tagged0, tagged1;

    //----------------------------------------
    // Classification and group resource check
    //----------------------------------------
    assign cls0     = classify(inst0);
    assign cls1     = classify(inst1);
    assign rob_need = {1'b0, inst0.is_valid} + {1'b0, inst1.is_valid};

    // Whole pair or nothing
    assign all_ok = fits(need_of(ALU, cls0, cls1), alu_rdy) &&
                    fits(need_of(MDU, cls0, cls1), mdu_rdy) &&
                    fits(need_of(LSQ, cls0, cls1), lsq_rdy) &&
                    fits(rob_need, rob_rdy);

    assign dispatch_rdy = all_ok;

    assign alu_we = {all_ok && cls1 == ALU, all_ok && cls0 == ALU};
    assign mdu_we = {all_ok && cls1 == MDU, all_ok && cls0 == MDU};
    assign lsq_we = {all_ok && cls1 == LSQ, all_ok && cls0 == LSQ};

    //----------------------------------------
    // Tag stamping, first written gets tail
    //----------------------------------------
    always_comb begin
        tagged0         = inst0;
        tagged0.rob_tag = alloc_tag0;
        tagged1         = inst1;
        tagged1.rob_tag = inst0.is_valid ? alloc_tag1 : alloc_tag0;
    end

    assign alu_entry0 = tagged0;
    assign alu_entry1 = tagged1;
    assign mdu_entry0 = tagged0;
    assign mdu_entry1 = tagged1;
    assign lsq_entry0 = tagged0;
    assign lsq_entry1 = tagged1;

    // ROB writes compacted so bit 1 implies bit 0
    assign rob_we     = {all_ok && rob_need == 2'd2, all_ok && rob_need != 2'd0};
    assign rob_entry0 = gen_rob_entry(inst0.is_valid ? inst0 : inst1);
    assign rob_entry1 = gen_rob_entry(inst1);

endmodule

/* inst_pkg.sv */
//----------------------------------------
// Instruction types for rename, dispatch and issue queues
// Needs rob_pkg compiled first
//----------------------------------------
`include "uarch_params.svh"

package inst_pkg;
    import rob_pkg::*;

    // Renamed instruction as it leaves rename
    typedef struct packed {
        logic                  is_valid;
        logic [`DATA_XLEN-1:0] pc;
        logic [`AREG_BITS-1:0] rd;
        logic [`PREG_BITS-1:0] prd;
        logic [`PREG_BITS-1:0] prs1;
        logic [`PREG_BITS-1:0] prs2;
        logic                  has_rd;
        logic                  is_load;
        logic                  is_store;
        logic                  is_muldiv;
        logic                  is_branch;
        logic                  is_jump;
        // Filled in by dispatch
        rob_tag_t              rob_tag;
    } renamed_inst_t;

    // Target queue of one instruction
    typedef enum logic [1:0] {NONE, ALU, MDU, LSQ} fu_class_t;

    // Free space of a queue or the ROB
    typedef struct packed {
        logic has_two;
        logic has_one;
    } slot_rdy_t;

endpackage

/* rob_pkg.sv */
//----------------------------------------
// Reorder buffer types shared by dispatch, ROB and top
//----------------------------------------
`include "uarch_params.svh"

package rob_pkg;

    // ROB index, wraps naturally at ROB_DEPTH
    typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;

    // One ROB slot
    typedef struct packed {
        logic                  is_valid;
        logic                  is_done;
        logic [`DATA_XLEN-1:0] pc;
        logic [`AREG_BITS-1:0] rd;
        logic                  has_rd;
        logic                  is_branch;
        logic                  is_jump;
        logic                  is_store;
    } rob_entry_t;

    // What the head presents at retirement
    typedef struct packed {
        rob_tag_t              rob_tag;
        logic [`DATA_XLEN-1:0] pc;
        logic [`AREG_BITS-1:0] rd;
        logic                  has_rd;
        logic                  is_store;
    } retire_rec_t;

endpackage

/* uarch_params.svh */
//----------------------------------------
// Widths and depths of the dispatch backend
// Include wherever a size is needed
//----------------------------------------
`ifndef UARCH_PARAMS_SVH
`define UARCH_PARAMS_SVH

// Program counter width
`define DATA_XLEN     32
// Physical and architectural register tags
`define PREG_BITS     6
`define AREG_BITS     5

// Reorder buffer, tag is log2 of depth
`define ROB_DEPTH     16
`define ROB_TAG_BITS  4

// Issue queue depths, powers of two
`define ALU_RS_DEPTH  8
`define MDU_RS_DEPTH  4
`define LSQ_DEPTH     8

`endif
